// ==== flist.f ====
decode_pkg.sv
strand_pc_counter.sv
strand_fetch_ctrl.sv
decode_stage.sv
register_file.sv
operand_fetch_top.sv
tb_operand_fetch.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_operand_fetch \
		-f flist.f -Mdir obj_dir
	./obj_dir/Vtb_operand_fetch | tee /dev/stderr | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

// ==== tb_operand_fetch.sv ====
// Front end testbench
`timescale 1ns/1ps
`default_nettype none

module tb_operand_fetch;
	import decode_pkg::*;

	typedef struct packed
	{
		reg_idx_t s1;
		reg_idx_t s2;
		reg_idx_t v1;
		reg_idx_t v2;
	} sels_t;

	typedef struct packed
	{
		logic [31:0] due;	// cycle when decoded_o shows it
		logic flushed;
		decoded_t exp;
		sels_t sel;
	} entry_t;

	logic clk, arst_n_i;
	logic wb_cyc_o, wb_stb_o, wb_ack_i;
	word_t wb_adr_o;
	instr_t wb_dat_i;
	redirect_t redirect_i;
	reg_write_t reg_write_i;
	decoded_t decoded_o;
	word_t scalar1_o, scalar2_o;
	word_t [3:0] vector1_o, vector2_o;

	instr_t mem [256];
	word_t sreg [REG_COUNT];	// expected register contents
	logic [127:0] vreg [REG_COUNT];
	word_t exp_pc [NUM_STRANDS];
	strand_t exp_strand;
	entry_t pend_q [$];
	logic [31:0] lfsr = 32'h05fc0db0;
	logic go, busy, timed_out, after_ack;
	word_t req_adr;
	int wait_left, cyc, fetch_cnt, dec_cnt, errors, checks;

	operand_fetch_top #(.LANES(4), .RESET_PC(32'h0)) DUT (
		.clk(clk), .arst_n_i(arst_n_i),
		.wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_adr_o(wb_adr_o),
		.wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i),
		.redirect_i(redirect_i), .reg_write_i(reg_write_i), .decoded_o(decoded_o),
		.scalar1_o(scalar1_o), .scalar2_o(scalar2_o),
		.vector1_o(vector1_o), .vector2_o(vector2_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// galois lfsr stepped once per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return r;
	endfunction

	function automatic word_t sext(input logic [12:0] v, input int bits);
		word_t w;
		w = 32'(v);
		for (int i = bits; i < 32; i++)
			w[i] = v[bits-1];	// copy sign bit up
		return w;
	endfunction

	function automatic instr_t mk_a(input logic [5:0] op, input logic [2:0] t,
		input logic [4:0] s2, input logic [4:0] m, input logic [4:0] d, input logic [4:0] s1);
		return {3'b110, op, t, s2, m, d, s1};
	endfunction

	function automatic instr_t mk_b(input logic [4:0] op, input logic [2:0] t,
		input logic [12:0] imm, input logic [4:0] d, input logic [4:0] s1);
		return {1'b0, op, t, imm, d, s1};
	endfunction

	function automatic instr_t mk_c(input logic ld, input logic [3:0] t, input logic [9:0] off,
		input logic [4:0] m, input logic [4:0] v, input logic [4:0] base);
		return {2'b10, ld, t, off, m, v, base};
	endfunction

	// expected selects from the register select rules
	function automatic sels_t expect_sels(input instr_t w, input strand_t s);
		sels_t r;
		logic fa, fc, vmem;
		fa = w[31:29] == 3'b110;
		fc = w[31:30] == 2'b10;
		vmem = w[28] || w[28:25] == 4'd7;
		r.s1 = (fa && w[22:20] >= 3'd1 && w[22:20] <= 3'd3) ? {s, w[14:10]} : {s, w[4:0]};
		if (fc && !w[29] && !vmem)
			r.s2 = {s, w[9:5]};
		else
			r.s2 = (fa && w[22:20] <= 3'd3) ? {s, w[19:15]} : {s, w[14:10]};
		r.v1 = {s, w[4:0]};
		r.v2 = (fa && w[22:20] >= 3'd4 && w[22:20] <= 3'd6) ? {s, w[19:15]} : {s, w[9:5]};
		return r;
	endfunction

	// reference decode of one word
	function automatic decoded_t expect_decode(input instr_t w, input strand_t s, input word_t pc);
		decoded_t d;
		logic fa, fb, fc, call, vmem;
		logic [2:0] at, bt;
		logic [3:0] ct;
		fa = w[31:29] == 3'b110;
		fb = !w[31];
		fc = w[31:30] == 2'b10;
		call = w[31:25] == 7'b1111100;
		at = w[22:20];
		bt = w[25:23];
		ct = w[28:25];
		vmem = ct[3] || ct == 4'd7;
		d = '0;
		d.valid = 1'b1;
		d.strand = s;
		d.pc = pc;
		d.instr = w;
		if (fb)
			d.immediate = (bt == 2 || bt == 3 || bt == 5 || bt == 6) ?
				sext({5'd0, w[22:15]}, 8) : sext(w[22:10], 13);
		else
			d.immediate = sext({3'd0, w[24:15]}, 10);
		d.alu_op = fa ? w[28:23] : (fb ? {1'b0, w[30:26]} : ALU_ADD);
		d.mask_src = MASK_ALL_ONES;
		if (fa && (at == 2 || at == 7))
			d.mask_src = MASK_SCALAR1;
		else if (fa && at == 3)
			d.mask_src = MASK_SCALAR1_INV;
		else if ((fa && at == 5) || (fb && (bt == 2 || bt == 5)))
			d.mask_src = MASK_SCALAR2;
		else if ((fa && at == 6) || (fb && (bt == 3 || bt == 6)))
			d.mask_src = MASK_SCALAR2_INV;
		else if (fc && (ct == 8 || ct == 11 || ct == 14))
			d.mask_src = MASK_SCALAR2;
		else if (fc && (ct == 9 || ct == 12 || ct == 15))
			d.mask_src = MASK_SCALAR2_INV;
		d.op1_is_vector = fa ? at != 0 : (fb ? (bt != 0 && !bt[2]) : (fc && ct >= 13));
		d.op2_src = fa ? (at[2] ? OP2_VECTOR : OP2_SCALAR) : OP2_IMMEDIATE;
		d.store_value_is_vector = !(fc && !vmem);
		d.has_writeback = (fa || fb || (fc && w[29]) || call) && w != 0;
		d.writeback_reg = call ? {s, 5'd30} : {s, w[9:5]};	// link register on call
		if (fa)
			d.writeback_is_vector = at != 0 && w[28:27] != 2'b01 && w[28:25] != 4'b1011;
		else if (fb)
			d.writeback_is_vector = !w[30] && bt != 0;
		else
			d.writeback_is_vector = !call && vmem;
		return d;
	endfunction

	task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("ERROR %s got %h exp %h", name, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond)
		else
		begin
			errors++;
			$display("%s at cycle %0d", what, cyc);
		end
	endtask

	task automatic check_entry(input entry_t e);
		check_true(decoded_o.valid, "decoded_o.valid missing two cycles after ack");
		check_val("decoded_o.strand", 128'(decoded_o.strand), 128'(e.exp.strand));
		check_val("decoded_o.pc", 128'(decoded_o.pc), 128'(e.exp.pc));
		check_val("decoded_o.instr", 128'(decoded_o.instr), 128'(e.exp.instr));
		check_val("decoded_o.immediate", 128'(decoded_o.immediate), 128'(e.exp.immediate));
		check_val("decoded_o.alu_op", 128'(decoded_o.alu_op), 128'(e.exp.alu_op));
		check_val("decoded_o.mask_src", 128'(decoded_o.mask_src), 128'(e.exp.mask_src));
		check_val("decoded_o.op1_is_vector", 128'(decoded_o.op1_is_vector),
			128'(e.exp.op1_is_vector));
		check_val("decoded_o.op2_src", 128'(decoded_o.op2_src), 128'(e.exp.op2_src));
		check_val("decoded_o.store_value_is_vector", 128'(decoded_o.store_value_is_vector),
			128'(e.exp.store_value_is_vector));
		check_val("decoded_o.has_writeback", 128'(decoded_o.has_writeback),
			128'(e.exp.has_writeback));
		check_val("decoded_o.writeback_reg", 128'(decoded_o.writeback_reg),
			128'(e.exp.writeback_reg));
		check_val("decoded_o.writeback_is_vector", 128'(decoded_o.writeback_is_vector),
			128'(e.exp.writeback_is_vector));
		check_val("scalar1_o", 128'(scalar1_o), 128'(sreg[e.sel.s1]));
		check_val("scalar2_o", 128'(scalar2_o), 128'(sreg[e.sel.s2]));
		check_val("vector1_o", vector1_o, vreg[e.sel.v1]);
		check_val("vector2_o", vector2_o, vreg[e.sel.v2]);
	endtask

	// output checker followed by the wishbone slave
	always @(posedge clk)
	begin
		entry_t e;
		int left;
		if (arst_n_i)
		begin
			if (redirect_i.valid)
				redirect_i <= '0;	// one cycle pulse
			if (pend_q.size() > 0 && pend_q[0].due == cyc)
			begin
				e = pend_q.pop_front();
				if (e.flushed)
				begin
					check_true(!decoded_o.valid, "flushed instruction reached decoded_o");
					check_val("decoded_o.has_writeback", 128'(decoded_o.has_writeback), 128'(0));
					check_val("decoded_o.instr", 128'(decoded_o.instr), 128'(0));
				end
				else
				begin
					check_entry(e);
					dec_cnt++;
				end
			end
			else
				check_true(!decoded_o.valid, "decoded_o.valid with no fetch behind it");

			if (after_ack)
				check_true(!wb_cyc_o && !wb_stb_o, "cyc or stb still high the cycle after ack");
			after_ack <= wb_ack_i;

			if (wb_ack_i)
			begin
				check_true(wb_cyc_o && wb_stb_o, "cyc or stb low in the ack cycle");
				check_val("wb_adr_o", 128'(wb_adr_o), 128'(req_adr));
				wb_ack_i <= 1'b0;
				busy <= 1'b0;
				e.due = 32'(cyc + 2);
				e.flushed = 1'b0;
				e.exp = expect_decode(wb_dat_i, exp_strand, exp_pc[exp_strand]);
				e.sel = expect_sels(wb_dat_i, exp_strand);
				exp_pc[exp_strand] = exp_pc[exp_strand] + 32'd4;
				if (fetch_cnt == 6 || fetch_cnt == 13)
				begin
					// redirect while the word sits in decode
					e.flushed = 1'b1;
					exp_pc[exp_strand] = fetch_cnt == 6 ? 32'h40 : 32'h80;
					redirect_i <= '{valid: 1'b1, strand: exp_strand,
						target_pc: exp_pc[exp_strand]};
				end
				pend_q.push_back(e);
				exp_strand = exp_strand + 2'd1;	// round robin
				fetch_cnt++;
			end
			else if (busy || (wb_cyc_o && wb_stb_o))
			begin
				if (!busy)
				begin
					check_val("wb_adr_o", 128'(wb_adr_o), 128'(exp_pc[exp_strand]));
					req_adr <= wb_adr_o;
					left = int'(rand_bits(2));	// 0 to 3 wait states
				end
				else
				begin
					check_true(wb_cyc_o && wb_stb_o, "cyc or stb dropped before ack");
					check_val("wb_adr_o", 128'(wb_adr_o), 128'(req_adr));
					left = wait_left;
				end
				busy <= 1'b1;
				if (go && left == 0)
				begin
					wb_ack_i <= 1'b1;
					wb_dat_i <= mem[wb_adr_o[9:2]];
				end
				else if (go)
					left--;
				wait_left <= left;
			end
			cyc++;
		end
	end

	task automatic write_reg(input logic is_vec, input reg_idx_t idx, input logic [127:0] data);
		reg_write_t w;
		w.enable = 1'b1;
		w.is_vector = is_vec;
		w.reg_idx = idx;
		w.data = data;
		@(posedge clk);
		reg_write_i <= w;
		if (is_vec)
			vreg[idx] = data;
		else
			sreg[idx] = data[31:0];	// lane 0
	endtask

	task automatic load_regs(input logic [31:0] salt);
		for (int i = 0; i < REG_COUNT; i++)
		begin
			write_reg(1'b0, reg_idx_t'(i), 128'(32'h5c000000 ^ salt ^ (i * 32'h00010203)));
			write_reg(1'b1, reg_idx_t'(i), {4{32'hec000000 ^ salt ^ (i * 32'h00070b0d)}}
				^ {32'd3, 32'd2, 32'd1, 32'd0});
		end
		@(posedge clk);
		reg_write_i <= '0;
	endtask

	task automatic wait_decoded(input int n);
		int t;
		t = 0;
		while (dec_cnt < n && t < 3000)
		begin
			@(posedge clk);
			t++;
		end
		if (dec_cnt < n)
		begin
			timed_out = 1'b1;
			$display("timeout waiting for decoded instruction %0d", n);
		end
	endtask

	initial
	begin
		instr_t w;
		int t;
		arst_n_i = 1'b0;
		wb_ack_i = 1'b0;
		wb_dat_i = '0;
		redirect_i = '0;
		reg_write_i = '0;
		go = 1'b0;
		busy = 1'b0;
		timed_out = 1'b0;
		after_ack = 1'b0;
		wait_left = 0;
		exp_strand = '0;
		for (int s = 0; s < NUM_STRANDS; s++)
			exp_pc[s] = 32'h0;
		for (int i = 0; i < 256; i++)
		begin
			w = rand_bits(32) ^ (i * 32'h9e3779b9);
			if (w[31:29] == 3'b111 && w[28:25] != 4'b1100)
				w[29] = 1'b0;	// no format D words
			mem[i] = w;
		end
		mem[0] = mk_a(6'h02, 3'd0, 5'd7, 5'd0, 5'd3, 5'd5);	// scalar
		mem[1] = mk_a(6'h03, 3'd2, 5'd9, 5'd4, 5'd6, 5'd1);	// vector/scalar masked
		mem[2] = mk_a(6'h04, 3'd4, 5'd11, 5'd0, 5'd8, 5'd2);
		mem[3] = mk_a(6'h05, 3'd6, 5'd12, 5'd13, 5'd10, 5'd3);
		mem[4] = mk_a(6'h12, 3'd1, 5'd14, 5'd0, 5'd2, 5'd4);	// compare
		mem[5] = mk_b(5'h04, 3'd0, 13'h1f00, 5'd1, 5'd7);
		mem[6] = mk_b(5'h05, 3'd2, 13'h1a3c, 5'd9, 5'd8);
		mem[7] = mk_b(5'h06, 3'd1, 13'h0abc, 5'd11, 5'd9);
		mem[8] = mk_c(1'b1, 4'd0, 10'h3f8, 5'd0, 5'd12, 5'd10);
		mem[9] = mk_c(1'b0, 4'd0, 10'h010, 5'd0, 5'd13, 5'd11);	// scalar store
		mem[10] = mk_c(1'b1, 4'd8, 10'h200, 5'd5, 5'd14, 5'd12);
		mem[11] = mk_c(1'b0, 4'he, 10'h155, 5'd6, 5'd15, 5'd13);	// gather store
		mem[12] = {7'b1111100, 25'h0123456};	// call
		mem[13] = 32'h0;
		mem[14] = mk_a(6'h2c, 3'd5, 5'd16, 5'd17, 5'd18, 5'd19);
		mem[15] = mk_b(5'h12, 3'd3, 13'h00ff, 5'd20, 5'd21);
		repeat (4) @(posedge clk);
		arst_n_i <= 1'b1;
		load_regs(32'h0);
		go <= 1'b1;
		wait_decoded(20);
		if (!timed_out)
		begin
			// stall fetch and drain before new register values
			go <= 1'b0;
			repeat (2) @(posedge clk);
			t = 0;
			while ((pend_q.size() > 0 || wb_ack_i) && t < 100)
			begin
				@(posedge clk);
				t++;
			end
			if (pend_q.size() > 0 || wb_ack_i)
			begin
				timed_out = 1'b1;
				$display("timeout draining the decode pipeline");
			end
		end
		if (!timed_out)
		begin
			load_regs(32'h00a5f00f);
			go <= 1'b1;
			wait_decoded(64);
		end
		$display("errors: %0d of %0d checks, decoded %0d", errors, checks, dec_cnt);
		if (errors == 0 && !timed_out)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== operand_fetch_top.sv ====
// Fetch, decode and operand read
`timescale 1ns/1ps
`default_nettype none

module operand_fetch_top #(
	parameter int unsigned LANES = 4,
	parameter decode_pkg::word_t RESET_PC = '0
) (
	input wire logic clk,
	input wire logic arst_n_i,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output decode_pkg::word_t wb_adr_o,
	input wire decode_pkg::instr_t wb_dat_i,
	input wire logic wb_ack_i,
	input wire decode_pkg::redirect_t redirect_i,
	input wire decode_pkg::reg_write_t reg_write_i,
	output decode_pkg::decoded_t decoded_o,
	output decode_pkg::word_t scalar1_o,
	output decode_pkg::word_t scalar2_o,
	output decode_pkg::word_t [LANES-1:0] vector1_o,
	output decode_pkg::word_t [LANES-1:0] vector2_o
);
	import decode_pkg::*;

	word_t pc;
	strand_t sel_strand;	// also the strand that advances on ack
	logic advance;
	fetched_t fetched;
	reg_idx_t scalar_sel1, scalar_sel2, vector_sel1, vector_sel2;

	strand_pc_counter #(
		.RESET_PC(RESET_PC)
	) u_pc_counter (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.advance_i(advance),
		.advance_strand_i(sel_strand),
		.redirect_i(redirect_i),
		.sel_strand_i(sel_strand),
		.pc_o(pc)
	);

	strand_fetch_ctrl u_fetch_ctrl (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.wb_cyc_o(wb_cyc_o),
		.wb_stb_o(wb_stb_o),
		.wb_adr_o(wb_adr_o),
		.wb_dat_i(wb_dat_i),
		.wb_ack_i(wb_ack_i),
		.pc_i(pc),
		.sel_strand_o(sel_strand),
		.advance_o(advance),
		.fetched_o(fetched)
	);

	decode_stage u_decode (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.fetched_i(fetched),
		.redirect_i(redirect_i),
		.scalar_sel1_o(scalar_sel1),
		.scalar_sel2_o(scalar_sel2),
		.vector_sel1_o(vector_sel1),
		.vector_sel2_o(vector_sel2),
		.decoded_o(decoded_o)
	);

	register_file #(
		.LANES(LANES)
	) u_regfile (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.scalar_sel1_i(scalar_sel1),
		.scalar_sel2_i(scalar_sel2),
		.vector_sel1_i(vector_sel1),
		.vector_sel2_i(vector_sel2),
		.write_i(reg_write_i),
		.scalar1_o(scalar1_o),
		.scalar2_o(scalar2_o),
		.vector1_o(vector1_o),
		.vector2_o(vector2_o)
	);

endmodule

`default_nettype wire

// ==== register_file.sv ====
// Scalar and vector register file
`timescale 1ns/1ps
`default_nettype none

module register_file #(
	parameter int unsigned LANES = 4
) (
	input wire logic clk,
	input wire logic arst_n_i,
	input wire decode_pkg::reg_idx_t scalar_sel1_i,
	input wire decode_pkg::reg_idx_t scalar_sel2_i,
	input wire decode_pkg::reg_idx_t vector_sel1_i,
	input wire decode_pkg::reg_idx_t vector_sel2_i,
	input wire decode_pkg::reg_write_t write_i,
	output decode_pkg::word_t scalar1_o,
	output decode_pkg::word_t scalar2_o,
	output decode_pkg::word_t [LANES-1:0] vector1_o,
	output decode_pkg::word_t [LANES-1:0] vector2_o
);
	import decode_pkg::*;

	word_t scalar_regs [REG_COUNT];
	word_t [LANES-1:0] vector_regs [REG_COUNT];
	logic scalar_we, vector_we;

	assign scalar_we = write_i.enable && !write_i.is_vector;
	assign vector_we = write_i.enable && write_i.is_vector;

	// one write port, steered by is_vector
	always_ff @(posedge clk)
	begin
		if (scalar_we)
			scalar_regs[write_i.reg_idx] <= write_i.data[0];	// lane 0 only
		if (vector_we)
			vector_regs[write_i.reg_idx] <= write_i.data[LANES-1:0];
	end

	// registered reads, same-cycle write shows up next time
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			scalar1_o <= '0;
			scalar2_o <= '0;
			vector1_o <= '0;
			vector2_o <= '0;
		end
		else
		begin
			scalar1_o <= scalar_regs[scalar_sel1_i];
			scalar2_o <= scalar_regs[scalar_sel2_i];
			vector1_o <= vector_regs[vector_sel1_i];
			vector2_o <= vector_regs[vector_sel2_i];
		end
	end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
// Instruction decode and register select
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input wire logic clk,
	input wire logic arst_n_i,
	input wire decode_pkg::fetched_t fetched_i,
	input wire decode_pkg::redirect_t redirect_i,
	output decode_pkg::reg_idx_t scalar_sel1_o,
	output decode_pkg::reg_idx_t scalar_sel2_o,
	output decode_pkg::reg_idx_t vector_sel1_o,
	output decode_pkg::reg_idx_t vector_sel2_o,
	output decode_pkg::decoded_t decoded_o
);
	import decode_pkg::*;

	instr_t instr;
	strand_t strand;
	logic is_fmt_a, is_fmt_b, is_fmt_c, is_call, is_vec_mem;
	logic [2:0] a_fmt_type, b_fmt_type;
	logic [3:0] c_op_type;
	logic [5:0] a_opcode;
	logic [4:0] b_opcode;
	logic flush;

	word_t imm_d;
	alu_op_t alu_op_d;
	mask_src_t mask_d;
	op2_src_t op2_d;
	logic op1_vec_d, store_vec_d, has_wb_d, wb_vec_d;
	reg_idx_t wb_reg_d;

	logic valid_q, has_wb_q;
	strand_t strand_q;
	word_t pc_q, imm_q;
	instr_t instr_q;
	alu_op_t alu_op_q;
	mask_src_t mask_q;
	op2_src_t op2_q;
	logic op1_vec_q, store_vec_q, wb_vec_q;
	reg_idx_t wb_reg_q;

	assign instr = fetched_i.instr;
	assign strand = fetched_i.strand;
	assign is_fmt_a = instr[31:29] == 3'b110;
	assign is_fmt_b = !instr[31];
	assign is_fmt_c = instr[31:30] == 2'b10;
	assign is_call = instr[31:25] == 7'b1111100;
	assign a_fmt_type = instr[22:20];
	assign b_fmt_type = instr[25:23];
	assign c_op_type = instr[28:25];
	assign a_opcode = instr[28:23];
	assign b_opcode = instr[30:26];
	assign is_vec_mem = c_op_type[3] || c_op_type == 4'b0111;	// block, strided, gather

	// selects leave unregistered, register file adds the cycle
	always_comb
	begin
		if (is_fmt_a && a_fmt_type inside {3'b001, 3'b010, 3'b011})
			scalar_sel1_o = {strand, instr[14:10]};	// mask, s2 busy with src2
		else
			scalar_sel1_o = {strand, instr[4:0]};

		if (is_fmt_c && !instr[29] && !is_vec_mem)
			scalar_sel2_o = {strand, instr[9:5]};	// scalar store value
		else if (is_fmt_a && a_fmt_type inside {3'b000, 3'b001, 3'b010, 3'b011})
			scalar_sel2_o = {strand, instr[19:15]};	// src2
		else
			scalar_sel2_o = {strand, instr[14:10]};	// mask

		if (is_fmt_a && a_fmt_type inside {3'b100, 3'b101, 3'b110})
			vector_sel2_o = {strand, instr[19:15]};	// src2
		else
			vector_sel2_o = {strand, instr[9:5]};	// store value
	end

	assign vector_sel1_o = {strand, instr[4:0]};

	always_comb
	begin
		if (is_fmt_b && b_fmt_type inside {3'b010, 3'b011, 3'b101, 3'b110})
			imm_d = {{24{instr[22]}}, instr[22:15]};	// masked, mask field eats bits
		else if (is_fmt_b)
			imm_d = {{19{instr[22]}}, instr[22:10]};
		else
			imm_d = {{22{instr[24]}}, instr[24:15]};	// memory offset

		if (is_fmt_a)
			op1_vec_d = a_fmt_type != 3'b000;
		else if (is_fmt_b)
			op1_vec_d = b_fmt_type != 3'b000 && !b_fmt_type[2];
		else if (is_fmt_c)
			op1_vec_d = c_op_type inside {4'b1101, 4'b1110, 4'b1111};	// gather base
		else
			op1_vec_d = 1'b0;

		if (is_fmt_a)
			op2_d = instr[22] ? OP2_VECTOR : OP2_SCALAR;
		else
			op2_d = OP2_IMMEDIATE;

		if (is_fmt_a)
			alu_op_d = instr[28:23];
		else if (is_fmt_b)
			alu_op_d = {1'b0, instr[30:26]};
		else
			alu_op_d = ALU_ADD;
	end

	// mask source per format
	always_comb
	begin
		mask_d = MASK_ALL_ONES;
		if (is_fmt_a)
		begin
			case (a_fmt_type)
				3'b010: mask_d = MASK_SCALAR1;	// vector/scalar masked
				3'b011: mask_d = MASK_SCALAR1_INV;
				3'b101: mask_d = MASK_SCALAR2;	// vector/vector masked
				3'b110: mask_d = MASK_SCALAR2_INV;
				3'b111: mask_d = MASK_SCALAR1;	// reserved
				default: mask_d = MASK_ALL_ONES;
			endcase
		end
		else if (is_fmt_b)
		begin
			case (b_fmt_type)
				3'b010, 3'b101: mask_d = MASK_SCALAR2;
				3'b011, 3'b110: mask_d = MASK_SCALAR2_INV;
				default: mask_d = MASK_ALL_ONES;
			endcase
		end
		else if (is_fmt_c)
		begin
			case (c_op_type)
				4'b1000, 4'b1011, 4'b1110: mask_d = MASK_SCALAR2;
				4'b1001, 4'b1100, 4'b1111: mask_d = MASK_SCALAR2_INV;
				default: mask_d = MASK_ALL_ONES;	// scalar, block, unmasked
			endcase
		end
	end

	assign store_vec_d = !(is_fmt_c && !is_vec_mem);
	// all-zero word is a nop
	assign has_wb_d = (is_fmt_a || is_fmt_b || (is_fmt_c && instr[29]) || is_call)
		&& instr != '0;
	assign wb_reg_d = is_call ? {strand, LINK_REG} : {strand, instr[9:5]};

	always_comb
	begin
		if (is_fmt_a)
			wb_vec_d = !(a_opcode[5:4] == 2'b01 || a_opcode[5:2] == 4'b1011)
				&& a_fmt_type != 3'b000;	// compares give a scalar
		else if (is_fmt_b)
			wb_vec_d = !b_opcode[4] && b_fmt_type != 3'b000;
		else if (is_call)
			wb_vec_d = 1'b0;
		else
			wb_vec_d = is_vec_mem;	// vector load
	end

	// drop the word if its strand is being redirected
	assign flush = redirect_i.valid && redirect_i.strand == strand;

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			valid_q <= 1'b0;
			has_wb_q <= 1'b0;
		end
		else
		begin
			valid_q <= fetched_i.valid && !flush;
			has_wb_q <= has_wb_d && !flush;
		end
	end

	always_ff @(posedge clk)
	begin
		instr_q <= flush ? '0 : instr;
		strand_q <= strand;
		pc_q <= fetched_i.pc;
		imm_q <= imm_d;
		alu_op_q <= alu_op_d;
		mask_q <= mask_d;
		op1_vec_q <= op1_vec_d;
		op2_q <= op2_d;
		store_vec_q <= store_vec_d;
		wb_reg_q <= wb_reg_d;
		wb_vec_q <= wb_vec_d;
	end

	always_comb
	begin
		decoded_o.valid = valid_q;
		decoded_o.strand = strand_q;
		decoded_o.pc = pc_q;
		decoded_o.instr = instr_q;
		decoded_o.immediate = imm_q;
		decoded_o.alu_op = alu_op_q;
		decoded_o.mask_src = mask_q;
		decoded_o.op1_is_vector = op1_vec_q;
		decoded_o.op2_src = op2_q;
		decoded_o.store_value_is_vector = store_vec_q;
		decoded_o.has_writeback = has_wb_q;
		decoded_o.writeback_reg = wb_reg_q;
		decoded_o.writeback_is_vector = wb_vec_q;
	end

endmodule

`default_nettype wire

// ==== strand_fetch_ctrl.sv ====
// Round-robin instruction fetch
`timescale 1ns/1ps
`default_nettype none

module strand_fetch_ctrl (
	input wire logic clk,
	input wire logic arst_n_i,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output decode_pkg::word_t wb_adr_o,
	input wire decode_pkg::instr_t wb_dat_i,
	input wire logic wb_ack_i,
	input wire decode_pkg::word_t pc_i,
	output decode_pkg::strand_t sel_strand_o,
	output logic advance_o,
	output decode_pkg::fetched_t fetched_o
);
	import decode_pkg::*;

	fetch_state_e state_q;
	fetch_state_e state_d;
	strand_t ptr_q;	// round-robin pointer
	word_t adr_q;
	instr_t instr_q;
	strand_t strand_q;	// strand of the captured word
	logic ack_seen;

	assign ack_seen = state_q == FETCH_REQ && wb_ack_i;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			FETCH_IDLE: state_d = FETCH_REQ;	// strand picked, address latched
			FETCH_REQ:
			begin
				if (wb_ack_i)
					state_d = FETCH_ISSUE;
			end
			FETCH_ISSUE: state_d = FETCH_IDLE;
			default: state_d = FETCH_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			state_q <= FETCH_IDLE;
			ptr_q <= '0;
		end
		else
		begin
			state_q <= state_d;
			if (ack_seen)
				ptr_q <= ptr_q + strand_t'(1);	// move on once the word is in
		end
	end

	always_ff @(posedge clk)
	begin
		if (state_q == FETCH_IDLE)
			adr_q <= pc_i;	// held stable for the whole cycle
		if (ack_seen)
		begin
			instr_q <= wb_dat_i;
			strand_q <= ptr_q;
		end
	end

	// classic read, we is always low
	assign wb_cyc_o = state_q == FETCH_REQ;
	assign wb_stb_o = state_q == FETCH_REQ;
	assign wb_adr_o = adr_q;

	assign sel_strand_o = ptr_q;
	assign advance_o = ack_seen;	// bump pc of the acked strand

	always_comb
	begin
		fetched_o.valid = state_q == FETCH_ISSUE;	// one cycle after ack
		fetched_o.strand = strand_q;
		fetched_o.pc = adr_q;
		fetched_o.instr = instr_q;
	end

endmodule

`default_nettype wire

// ==== strand_pc_counter.sv ====
// Per-strand program counters
`timescale 1ns/1ps
`default_nettype none

module strand_pc_counter #(
	parameter decode_pkg::word_t RESET_PC = '0
) (
	input wire logic clk,
	input wire logic arst_n_i,
	input wire logic advance_i,
	input wire decode_pkg::strand_t advance_strand_i,
	input wire decode_pkg::redirect_t redirect_i,
	input wire decode_pkg::strand_t sel_strand_i,
	output decode_pkg::word_t pc_o
);
	import decode_pkg::*;

	word_t pc_q [NUM_STRANDS];
	logic [NUM_STRANDS-1:0] stale_q;	// redirected while its fetch was in flight

	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
				pc_q[s] <= RESET_PC;
			stale_q <= '0;
		end
		else
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				if (redirect_i.valid && redirect_i.strand == strand_t'(s))
				begin
					pc_q[s] <= redirect_i.target_pc;	// wins over increment
					// fetch of this strand already uses the old pc
					stale_q[s] <= sel_strand_i == strand_t'(s)
						&& !(advance_i && advance_strand_i == strand_t'(s));
				end
				else if (advance_i && advance_strand_i == strand_t'(s))
				begin
					if (!stale_q[s])
						pc_q[s] <= pc_q[s] + 32'd4;	// next word
					stale_q[s] <= 1'b0;	// keep target for the next round
				end
			end
		end
	end

	assign pc_o = pc_q[sel_strand_i];	// pc of strand being fetched

endmodule

`default_nettype wire

// ==== decode_pkg.sv ====
// Front end shared types
`default_nettype none

package decode_pkg;

	localparam int unsigned NUM_STRANDS = 4;
	localparam int unsigned REG_COUNT = 128;	// 4 strands x 32 regs
	localparam int unsigned MAX_LANES = 4;	// width of a register write

	typedef logic [31:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [1:0] strand_t;
	typedef logic [6:0] reg_idx_t;	// {strand, reg field}
	typedef logic [2:0] mask_src_t;
	typedef logic [1:0] op2_src_t;
	typedef logic [5:0] alu_op_t;

	// mask source codes as seen by execute
	localparam mask_src_t MASK_SCALAR1 = 3'd0;
	localparam mask_src_t MASK_SCALAR1_INV = 3'd1;
	localparam mask_src_t MASK_SCALAR2 = 3'd2;
	localparam mask_src_t MASK_SCALAR2_INV = 3'd3;
	localparam mask_src_t MASK_ALL_ONES = 3'd4;

	localparam op2_src_t OP2_SCALAR = 2'd0;
	localparam op2_src_t OP2_VECTOR = 2'd1;
	localparam op2_src_t OP2_IMMEDIATE = 2'd2;

	localparam alu_op_t ALU_ADD = 6'b000101;	// address offset add
	localparam logic [4:0] LINK_REG = 5'd30;	// call return address

	typedef enum logic [1:0]
	{
		FETCH_IDLE,
		FETCH_REQ,
		FETCH_ISSUE
	} fetch_state_e;

	typedef struct packed
	{
		logic valid;
		strand_t strand;
		word_t pc;
		instr_t instr;
	} fetched_t;

	typedef struct packed
	{
		logic valid;
		strand_t strand;
		word_t pc;
		instr_t instr;
		word_t immediate;
		alu_op_t alu_op;
		mask_src_t mask_src;
		logic op1_is_vector;
		op2_src_t op2_src;
		logic store_value_is_vector;
		logic has_writeback;
		reg_idx_t writeback_reg;
		logic writeback_is_vector;
	} decoded_t;

	typedef struct packed
	{
		logic enable;
		logic is_vector;
		reg_idx_t reg_idx;
		word_t [MAX_LANES-1:0] data;	// scalar uses lane 0
	} reg_write_t;

	typedef struct packed
	{
		logic valid;
		strand_t strand;
		word_t target_pc;
	} redirect_t;

endpackage

`default_nettype wire
